// File: hw/exePkg.sv
//********************************************************************
// shared types of the execute stage
// opcode, branch kind, mul/div state and forward source enums
// decode-to-execute, later-stage write and execute-to-MEM bundles
//********************************************************************
package exePkg;

    typedef enum logic [4:0] {
        NOP,   ADD,   ADDU,  SUB,   SUBU,
        AND,   OR,    XOR,   NOR,   SLT,
        SLTU,  SLL,   SRL,   SRA,   LUI,
        MULT,  MULTU, DIV,   DIVU,  MFHI,
        MFLO,  MTHI,  MTLO
    } aluOpE;

    typedef enum logic [2:0] {
        NONE, BEQ, BNE, BLEZ, BGTZ, JR, J, JAL
    } branchE;

    typedef enum logic [1:0] {
        IDLE, BUSY, DONE
    } mdStateE;

    typedef enum logic [1:0] {
        REG, MEM, MEM2, WB
    } fwdSelE;

    typedef struct packed {
        logic gprWr;
        logic hiWr;
        logic loWr;
    } regsWrT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] busA;
        logic [31:0] busB;
        logic [31:0] imm32;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [4:0]  shamt;
        aluOpE       aluOp;
        logic        aluSrcA;     // shamt as operand A
        logic        aluSrcB;     // imm32 as operand B
        branchE      branch;
        regsWrT      regsWr;
        logic        ovfTrap;     // trapping ADD/SUB forms
    } idExeT;

    // one write from a later stage
    typedef struct packed {
        logic        gprWr;
        logic [4:0]  dst;
        logic [31:0] result;
    } fwdSrcT;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] storeData;
        logic [4:0]  dst;
        regsWrT      regsWr;
        logic        excOverflow;
    } exeMemT;

endpackage

// File: hw/exeStageReg.sv
//********************************************************************
// decode-to-execute pipeline register
// holds on low exeWr, loads a bubble on flush
//********************************************************************
module exeStageReg import exePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  exeWr,
    input  logic  exeFlush,
    input  idExeT idIn,
    output idExeT stage
);

    // all zeros decodes as NOP, NONE, no writes
    localparam idExeT Bubble = '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage <= Bubble;
        end else if (exeWr) begin
            if (exeFlush) begin
                stage <= Bubble;
            end else begin
                stage <= idIn;
            end
        end
    end

endmodule

// File: hw/operandForward.sv
//********************************************************************
// operand forwarding from MEM, MEM2 and WB
// plus the shamt and immediate operand selection
//********************************************************************
module operandForward import exePkg::*; (
    input  idExeT       stage,
    input  fwdSrcT      memFwd,
    input  fwdSrcT      mem2Fwd,
    input  fwdSrcT      wbFwd,
    output logic [31:0] opA,
    output logic [31:0] opB,
    output logic [31:0] aluA,
    output logic [31:0] aluB
);

    fwdSelE selA;
    fwdSelE selB;

    function automatic logic fwdHit(input fwdSrcT src, input logic [4:0] rIdx);
        return src.gprWr && (src.dst != 5'd0) && (src.dst == rIdx);
    endfunction

    function automatic fwdSelE pickSrc(input logic [4:0] rIdx, input fwdSrcT m,
                                       input fwdSrcT m2, input fwdSrcT w);
        if (fwdHit(m, rIdx)) begin
            return MEM;         // youngest wins
        end else if (fwdHit(m2, rIdx)) begin
            return MEM2;
        end else if (fwdHit(w, rIdx)) begin
            return WB;
        end
        return REG;
    endfunction

    function automatic logic [31:0] pickData(input fwdSelE sel, input logic [31:0] regVal,
                                             input fwdSrcT m, input fwdSrcT m2,
                                             input fwdSrcT w);
        case (sel)
            MEM:     return m.result;
            MEM2:    return m2.result;
            WB:      return w.result;
            default: return regVal;
        endcase
    endfunction

    assign selA = pickSrc(stage.rs, memFwd, mem2Fwd, wbFwd);
    assign selB = pickSrc(stage.rt, memFwd, mem2Fwd, wbFwd);

    assign opA  = pickData(selA, stage.busA, memFwd, mem2Fwd, wbFwd);
    assign opB  = pickData(selB, stage.busB, memFwd, mem2Fwd, wbFwd);

    assign aluA = stage.aluSrcA ? {27'b0, stage.shamt} : opA;
    assign aluB = stage.aluSrcB ? stage.imm32 : opB;

endmodule

// File: hw/aluCore.sv
//********************************************************************
// combinational ALU
// logic, add/sub, compare, shift and LUI with signed overflow flag
//********************************************************************
module aluCore import exePkg::*; (
    input  logic [31:0] aluA,
    input  logic [31:0] aluB,
    input  aluOpE       aluOp,
    output logic [31:0] aluOut,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = aluA + aluB;
    assign diff = aluA - aluB;

    always_comb begin
        aluOut   = '0;
        overflow = 1'b0;
        case (aluOp)
            ADD: begin
                aluOut   = sum;
                overflow = (aluA[31] == aluB[31]) && (sum[31] != aluA[31]);
            end
            SUB: begin
                aluOut   = diff;
                overflow = (aluA[31] != aluB[31]) && (diff[31] != aluA[31]);
            end
            ADDU: aluOut = sum;
            SUBU: aluOut = diff;
            AND:  aluOut = aluA & aluB;
            OR:   aluOut = aluA | aluB;
            XOR:  aluOut = aluA ^ aluB;
            NOR:  aluOut = ~(aluA | aluB);
            SLT:  aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
            SLTU: aluOut = {31'b0, aluA < aluB};
            SLL:  aluOut = aluB << aluA[4:0];      // amount from operand A
            SRL:  aluOut = aluB >> aluA[4:0];
            SRA:  aluOut = $unsigned($signed(aluB) >>> aluA[4:0]);
            LUI:  aluOut = {aluB[15:0], 16'b0};
            default: aluOut = '0;
        endcase
    end

endmodule

// File: hw/mulDivHiLo.sv
//********************************************************************
// iterative multiply and divide unit with the HI and LO registers
// radix-2 shift-add multiply, restoring divide, sign fix at the end
//********************************************************************
module mulDivHiLo import exePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  aluOpE       aluOp,
    input  logic        mdStart,
    input  logic        mdAbort,
    input  regsWrT      hiloWr,
    output logic        mdDone,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic        busy;
    logic        isDiv;
    logic        signA;
    logic        signB;
    logic [5:0]  bitCnt;
    logic [31:0] magB;
    logic [63:0] shReg;        // {hi part, lo part} while iterating
    logic [63:0] shNext;
    logic [32:0] addRes;
    logic [32:0] trial;
    logic        signedOp;
    logic [31:0] magA0;
    logic [31:0] magB0;
    logic [63:0] prod;
    logic [31:0] quot;
    logic [31:0] rem;

    assign signedOp = (aluOp == MULT) || (aluOp == DIV);
    assign magA0    = (signedOp && opA[31]) ? -opA : opA;
    assign magB0    = (signedOp && opB[31]) ? -opB : opB;

    always_comb begin
        addRes = {1'b0, shReg[63:32]} + (shReg[0] ? {1'b0, magB} : 33'd0);
        trial  = shReg[63:31] - {1'b0, magB};
        if (isDiv) begin
            shNext = trial[32] ? {shReg[62:0], 1'b0} : {trial[31:0], shReg[30:0], 1'b1};
        end else begin
            shNext = {addRes, shReg[31:1]};
        end
    end

    assign mdDone = busy && (bitCnt == 6'd32);

    // zero divisor leaves the all-ones quotient as is
    assign prod = (signA ^ signB) ? -shReg : shReg;
    assign quot = ((signA ^ signB) && (magB != 32'd0)) ? -shReg[31:0] : shReg[31:0];
    assign rem  = signA ? -shReg[63:32] : shReg[63:32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy   <= 1'b0;
            bitCnt <= '0;
            isDiv  <= 1'b0;
            signA  <= 1'b0;
            signB  <= 1'b0;
        end else if (mdAbort) begin
            busy <= 1'b0;
        end else if (mdStart) begin
            busy   <= 1'b1;
            bitCnt <= '0;
            isDiv  <= (aluOp == DIV) || (aluOp == DIVU);
            signA  <= signedOp && opA[31];
            signB  <= signedOp && opB[31];
        end else if (busy) begin
            if (mdDone) begin
                busy <= 1'b0;
            end else begin
                bitCnt <= bitCnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mdStart) begin
            magB  <= magB0;
            shReg <= {32'b0, magA0};
        end else if (busy && !mdDone) begin
            shReg <= shNext;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (mdDone && !mdAbort) begin
            if (isDiv) begin
                hi <= rem;
                lo <= quot;
            end else begin
                hi <= prod[63:32];
                lo <= prod[31:0];
            end
        end else begin
            if (hiloWr.hiWr) begin
                hi <= opA;      // MTHI
            end
            if (hiloWr.loWr) begin
                lo <= opA;      // MTLO
            end
        end
    end

endmodule

// File: hw/exeCtrl.sv
//********************************************************************
// execute stage control
// mul/div FSM and stall, branch resolution, overflow and write gating
//********************************************************************
module exeCtrl import exePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  idExeT       stage,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  logic        overflow,
    input  logic        exeFlush,
    input  logic        mdDone,
    output logic        mdStart,
    output logic        mdAbort,
    output regsWrT      hiloWr,
    output logic        gprWrOut,
    output logic        excOverflow,
    output logic        mulDivStall,
    output logic        branchFlush,
    output logic [31:0] branchTarget
);

    mdStateE     mdState;
    logic [31:0] mdPc;         // pc of the mul/div in flight
    logic        isMd;
    logic        mdLeave;
    logic        trapOvf;
    logic        taken;
    logic [31:0] pc4;

    assign isMd    = (stage.aluOp inside {MULT, MULTU, DIV, DIVU});
    assign mdLeave = !isMd || (stage.pc != mdPc);   // new instruction in the stage
    assign mdStart = (mdState == IDLE) && isMd && !exeFlush;
    assign mdAbort = (mdState == BUSY) && exeFlush;
    assign mulDivStall = mdStart || ((mdState == BUSY) && !mdDone && !exeFlush);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mdState <= IDLE;
        end else begin
            case (mdState)
                IDLE:    mdState <= mdStart ? BUSY : IDLE;
                BUSY:    mdState <= mdAbort ? IDLE : (mdDone ? DONE : BUSY);
                DONE:    mdState <= mdLeave ? IDLE : DONE;
                default: mdState <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mdStart) begin
            mdPc <= stage.pc;
        end
    end

    assign trapOvf     = overflow && stage.ovfTrap;
    assign excOverflow = trapOvf && !exeFlush;
    assign gprWrOut    = stage.regsWr.gprWr && !trapOvf && !exeFlush;

    // MTHI/MTLO only, mul/div results go through mdDone
    assign hiloWr.gprWr = 1'b0;
    assign hiloWr.hiWr  = stage.regsWr.hiWr && !isMd && !trapOvf && !exeFlush;
    assign hiloWr.loWr  = stage.regsWr.loWr && !isMd && !trapOvf && !exeFlush;

    assign pc4 = stage.pc + 32'd4;

    always_comb begin
        taken        = 1'b0;
        branchTarget = pc4 + {stage.imm32[29:0], 2'b00};
        case (stage.branch)
            BEQ:  taken = (opA == opB);
            BNE:  taken = (opA != opB);
            BLEZ: taken = opA[31] || (opA == 32'd0);
            BGTZ: taken = !opA[31] && (opA != 32'd0);
            J, JAL: begin
                taken        = 1'b1;
                branchTarget = {pc4[31:28], stage.imm32[25:0], 2'b00};
            end
            JR: begin
                taken        = 1'b1;
                branchTarget = opA;
            end
            default: taken = 1'b0;
        endcase
    end

    assign branchFlush = taken && !exeFlush;

endmodule

// File: hw/exeTop.sv
//********************************************************************
// execute stage top level
// stage register, forwarding, ALU, mul/div with HI/LO and control
//********************************************************************
module exeTop import exePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  idExeT       idIn,
    input  logic        exeWr,
    input  logic        exeFlush,
    input  fwdSrcT      memFwd,
    input  fwdSrcT      mem2Fwd,
    input  fwdSrcT      wbFwd,
    output exeMemT      exeOut,
    output logic        branchFlush,
    output logic [31:0] branchTarget,
    output logic        mulDivStall
);

    idExeT       stage;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluOut;
    logic        overflow;
    logic        mdStart;
    logic        mdAbort;
    logic        mdDone;
    regsWrT      hiloWr;
    logic        gprWrOut;
    logic        excOverflow;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] result;

    exeStageReg u_exeStageReg (
        .clk      (clk),
        .rstN     (rstN),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .idIn     (idIn),
        .stage    (stage)
    );

    operandForward u_operandForward (
        .stage   (stage),
        .memFwd  (memFwd),
        .mem2Fwd (mem2Fwd),
        .wbFwd   (wbFwd),
        .opA     (opA),
        .opB     (opB),
        .aluA    (aluA),
        .aluB    (aluB)
    );

    aluCore u_aluCore (
        .aluA     (aluA),
        .aluB     (aluB),
        .aluOp    (stage.aluOp),
        .aluOut   (aluOut),
        .overflow (overflow)
    );

    mulDivHiLo u_mulDivHiLo (
        .clk     (clk),
        .rstN    (rstN),
        .opA     (opA),         // forwarded, before shamt/imm select
        .opB     (opB),
        .aluOp   (stage.aluOp),
        .mdStart (mdStart),
        .mdAbort (mdAbort),
        .hiloWr  (hiloWr),
        .mdDone  (mdDone),
        .hi      (hi),
        .lo      (lo)
    );

    exeCtrl u_exeCtrl (
        .clk          (clk),
        .rstN         (rstN),
        .stage        (stage),
        .opA          (opA),
        .opB          (opB),
        .overflow     (overflow),
        .exeFlush     (exeFlush),
        .mdDone       (mdDone),
        .mdStart      (mdStart),
        .mdAbort      (mdAbort),
        .hiloWr       (hiloWr),
        .gprWrOut     (gprWrOut),
        .excOverflow  (excOverflow),
        .mulDivStall  (mulDivStall),
        .branchFlush  (branchFlush),
        .branchTarget (branchTarget)
    );

    always_comb begin
        case (stage.aluOp)
            MFHI:    result = hi;
            MFLO:    result = lo;
            default: result = aluOut;
        endcase
        if (stage.branch == JAL) begin
            result = stage.pc + 32'd8;      // link address
        end
    end

    assign exeOut.result       = result;
    assign exeOut.storeData    = opB;
    assign exeOut.dst          = stage.dst;
    assign exeOut.regsWr.gprWr = gprWrOut;
    assign exeOut.regsWr.hiWr  = hiloWr.hiWr;
    assign exeOut.regsWr.loWr  = hiloWr.loWr;
    assign exeOut.excOverflow  = excOverflow;

endmodule

// File: dv/exeTb.sv
//********************************************************************
// testbench for the execute stage
// reference model for ALU, forwarding, branches and mul/div
// flush, hold and overflow tests, watchdog and error summary
//********************************************************************
module exeTb import exePkg::*; ();

    localparam int ClkPeriod = 40;
    localparam int NumAlu = 8;          // rounds per ALU opcode
    localparam int NumFwd = 40;
    localparam int NumMd = 6;           // rounds per mul/div opcode
    localparam int TestCycles = 2 * (16 + 14 * NumAlu * 2 + NumFwd * 2 + 40
                                     + (4 * NumMd + 3) * 45 + 100);
    localparam fwdSrcT NoFwd = '0;
    localparam aluOpE AluOps[14] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
                                     SLT, SLTU, SLL, SRL, SRA, LUI};

    logic        clk;
    logic        rstN;
    idExeT       idIn;
    logic        exeWr;
    logic        exeFlush;
    fwdSrcT      memFwd;
    fwdSrcT      mem2Fwd;
    fwdSrcT      wbFwd;
    exeMemT      exeOut;
    logic        branchFlush;
    logic [31:0] branchTarget;
    logic        mulDivStall;
    int          errCount;
    int          checkCount;
    logic [31:0] pcNext;

    exeTop u_exeTop (
        .clk          (clk),
        .rstN         (rstN),
        .idIn         (idIn),
        .exeWr        (exeWr),
        .exeFlush     (exeFlush),
        .memFwd       (memFwd),
        .mem2Fwd      (mem2Fwd),
        .wbFwd        (wbFwd),
        .exeOut       (exeOut),
        .branchFlush  (branchFlush),
        .branchTarget (branchTarget),
        .mulDivStall  (mulDivStall)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    flushBeatsBranch: assert property (@(posedge clk) disable iff (!rstN)
                                       !(exeFlush && branchFlush))
        else begin
            errCount++;
            $display("branchFlush was raised while exeFlush was high");
        end

    ovfKillsWrite: assert property (@(posedge clk) disable iff (!rstN)
                                    exeOut.excOverflow |-> !exeOut.regsWr.gprWr)
        else begin
            errCount++;
            $display("overflow exception left the register write enabled");
        end

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        assert (act === exp) else begin
            errCount++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] aluModel(input aluOpE op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{b[31]}}, b};
        case (op)
            ADD, ADDU: return a + b;
            SUB, SUBU: return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            NOR:       return ~(a | b);
            SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      return (a < b) ? 32'd1 : 32'd0;
            SLL:       return b << a[4:0];
            SRL:       return b >> a[4:0];
            SRA: begin
                ext = ext >> a[4:0];   // sign bits shift in from the top
                return ext[31:0];
            end
            LUI:       return b << 16;
            default:   return 32'd0;
        endcase
    endfunction

    // result does not fit 32 signed bits
    function automatic logic ovfModel(input aluOpE op, input logic [31:0] a,
                                      input logic [31:0] b);
        longint s;
        if (op == ADD) begin
            s = longint'($signed(a)) + longint'($signed(b));
        end else if (op == SUB) begin
            s = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        return s != longint'($signed(s[31:0]));
    endfunction

    function automatic logic [31:0] fwdModel(input logic [4:0] r, input logic [31:0] regVal,
                                             input fwdSrcT src [3]);
        for (int i = 0; i < 3; i++) begin
            if (r != 5'd0 && src[i].gprWr && src[i].dst == r) begin
                return src[i].result;
            end
        end
        return regVal;
    endfunction

    // {hi, lo} after a multiply or divide
    function automatic logic [63:0] mdModel(input aluOpE op, input logic [31:0] a,
                                            input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      q;
        longint      r;
        logic [63:0] ua;
        logic [63:0] ub;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'b0, a};
        ub = {32'b0, b};
        if ((op == DIV || op == DIVU) && b == 32'd0) begin
            return {a, 32'hFFFF_FFFF};
        end
        case (op)
            MULT:  return sa * sb;
            MULTU: return ua * ub;
            DIV: begin
                q = sa / sb;
                r = sa % sb;
                return {r[31:0], q[31:0]};
            end
            default: return {32'(ua % ub), 32'(ua / ub)};
        endcase
    endfunction

    function automatic idExeT mkInstr(input aluOpE op, input logic [31:0] a,
                                      input logic [31:0] b);
        idExeT t;
        t = '0;
        t.aluOp = op;
        t.busA = a;
        t.busB = b;
        t.rs = 5'd1;
        t.rt = 5'd2;
        t.dst = 5'd3;
        t.regsWr.gprWr = 1'b1;
        return t;
    endfunction

    // captures one instruction, then holds it in the stage
    task automatic issue(input idExeT t, input fwdSrcT m, input fwdSrcT m2, input fwdSrcT w);
        @(posedge clk);
        #2;
        idIn = t;
        idIn.pc = pcNext;
        pcNext = pcNext + 32'd4;
        memFwd = m;
        mem2Fwd = m2;
        wbFwd = w;
        exeWr = 1'b1;
        @(posedge clk);
        #2;
        exeWr = 1'b0;
        @(negedge clk);
    endtask

    task automatic readHiLo(input string name, input logic [31:0] hiExp,
                            input logic [31:0] loExp);
        issue(mkInstr(MFHI, 32'd0, 32'd0), NoFwd, NoFwd, NoFwd);
        checkVal({name, " HI"}, hiExp, exeOut.result);
        issue(mkInstr(MFLO, 32'd0, 32'd0), NoFwd, NoFwd, NoFwd);
        checkVal({name, " LO"}, loExp, exeOut.result);
    endtask

    task automatic waitMdDone(input string name);
        int n;
        n = 0;
        checkCount++;
        assert (mulDivStall) else begin
            errCount++;
            $display("%s did not raise mulDivStall", name);
        end
        while (mulDivStall && n < 100) begin
            @(negedge clk);
            n++;
        end
        assert (!mulDivStall) else begin
            errCount++;
            $display("%s never finished, mulDivStall stuck high", name);
        end
    endtask

    task automatic aluTest(input aluOpE op, input logic useShamt, input logic useImm);
        idExeT       t;
        logic [31:0] a;
        logic [31:0] b;
        t = mkInstr(op, $urandom(), $urandom());
        t.shamt = 5'($urandom());
        t.imm32 = $urandom();
        t.dst = 5'($urandom_range(31, 1));
        t.aluSrcA = useShamt;
        t.aluSrcB = useImm;
        a = useShamt ? {27'b0, t.shamt} : t.busA;
        b = useImm ? t.imm32 : t.busB;
        issue(t, NoFwd, NoFwd, NoFwd);
        checkVal({op.name(), " result"}, aluModel(op, a, b), exeOut.result);
        checkVal({op.name(), " dst/regsWr"}, {24'b0, t.dst, 3'b100},
                 {24'b0, exeOut.dst, exeOut.regsWr});
    endtask

    task automatic fwdTest();
        idExeT       t;
        fwdSrcT      src [3];
        logic [31:0] expA;
        logic [31:0] expB;
        t = mkInstr(ADDU, $urandom(), $urandom());
        t.rs = 5'($urandom_range(3, 0));    // small range so hits and r0 show up
        t.rt = 5'($urandom_range(3, 0));
        for (int i = 0; i < 3; i++) begin
            src[i].gprWr = 1'($urandom());
            src[i].dst = 5'($urandom_range(3, 0));
            src[i].result = $urandom();
        end
        expA = fwdModel(t.rs, t.busA, src);
        expB = fwdModel(t.rt, t.busB, src);
        issue(t, src[0], src[1], src[2]);
        checkVal("forward opA+opB", expA + expB, exeOut.result);
        checkVal("forward storeData", expB, exeOut.storeData);
    endtask

    task automatic branchTest(input branchE br, input logic [31:0] a, input logic [31:0] b,
                              input logic viaFwd);
        idExeT       t;
        fwdSrcT      m;
        logic        taken;
        logic [31:0] pc4;
        logic [31:0] target;
        logic [31:0] r;
        r = $urandom();
        t = mkInstr(NOP, viaFwd ? ~a : a, b);   // stale register value when forwarded
        t.branch = br;
        t.imm32 = {{16{r[15]}}, r[15:0]};
        t.dst = 5'd31;
        t.regsWr.gprWr = (br == JAL);
        m.gprWr = viaFwd;
        m.dst = t.rs;
        m.result = a;
        pc4 = pcNext + 32'd4;
        target = pc4 + (t.imm32 << 2);
        case (br)
            BEQ:  taken = (a == b);
            BNE:  taken = (a != b);
            BLEZ: taken = ($signed(a) <= 0);
            BGTZ: taken = ($signed(a) > 0);
            JR: begin
                taken = 1'b1;
                target = a;
            end
            default: begin
                taken = 1'b1;
                target = (pc4 & 32'hF000_0000) | ((t.imm32 << 2) & 32'h0FFF_FFFF);
            end
        endcase
        issue(t, m, NoFwd, NoFwd);
        checkVal({br.name(), " taken"}, {31'b0, taken}, {31'b0, branchFlush});
        if (taken) begin
            checkVal({br.name(), " target"}, target, branchTarget);
        end
        if (br == JAL) begin
            checkVal("JAL link", pc4 + 32'd4, exeOut.result);
            checkVal("JAL gprWr", 32'd1, {31'b0, exeOut.regsWr.gprWr});
        end
    endtask

    task automatic mdTest(input aluOpE op, input logic [31:0] a, input logic [31:0] b);
        idExeT       t;
        logic [63:0] exp;
        exp = mdModel(op, a, b);
        t = mkInstr(op, a, b);
        t.regsWr = '0;
        issue(t, NoFwd, NoFwd, NoFwd);
        waitMdDone(op.name());
        readHiLo(op.name(), exp[63:32], exp[31:0]);
    endtask

    task automatic moveHiLo(input logic [31:0] hv, input logic [31:0] lv);
        idExeT t;
        t = mkInstr(MTHI, hv, 32'd0);
        t.regsWr = '0;
        t.regsWr.hiWr = 1'b1;
        issue(t, NoFwd, NoFwd, NoFwd);
        t = mkInstr(MTLO, lv, 32'd0);
        t.regsWr = '0;
        t.regsWr.loWr = 1'b1;
        issue(t, NoFwd, NoFwd, NoFwd);
        readHiLo("MTHI/MTLO", hv, lv);
    endtask

    task automatic flushHoldTest();
        idExeT       t;
        logic [31:0] hv;
        logic [31:0] lv;
        t = mkInstr(NOP, 32'd0, 32'd0);
        t.branch = J;
        t.regsWr = '0;
        issue(t, NoFwd, NoFwd, NoFwd);
        checkVal("flush branch taken", 32'd1, {31'b0, branchFlush});
        @(posedge clk);
        #2;
        idIn = mkInstr(ADDU, $urandom(), $urandom());
        exeWr = 1'b1;
        exeFlush = 1'b1;                // jump still in the stage
        @(posedge clk);
        #2;
        exeWr = 1'b0;
        exeFlush = 1'b0;
        @(negedge clk);
        checkVal("flush result", 32'd0, exeOut.result);
        checkVal("flush dst/regsWr", 32'd0,
                 {23'b0, exeOut.dst, exeOut.regsWr, exeOut.excOverflow});
        t = mkInstr(XOR, $urandom(), $urandom());
        issue(t, NoFwd, NoFwd, NoFwd);
        repeat (4) begin
            @(posedge clk);
            #2;
            idIn = mkInstr(SUBU, $urandom(), $urandom());  // must not get in
        end
        @(negedge clk);
        checkVal("hold result", aluModel(XOR, t.busA, t.busB), exeOut.result);
        checkVal("hold storeData", t.busB, exeOut.storeData);
        hv = $urandom();
        lv = $urandom();
        moveHiLo(hv, lv);
        t = mkInstr(DIV, $urandom(), 32'd7);
        t.regsWr = '0;
        issue(t, NoFwd, NoFwd, NoFwd);
        repeat (5) @(negedge clk);
        checkVal("divide busy", 32'd1, {31'b0, mulDivStall});
        @(posedge clk);
        #2;
        exeFlush = 1'b1;
        exeWr = 1'b1;
        @(posedge clk);
        #2;
        exeFlush = 1'b0;
        exeWr = 1'b0;
        @(negedge clk);
        checkVal("abort stall", 32'd0, {31'b0, mulDivStall});
        repeat (40) @(negedge clk);     // past the point a running divide would finish
        readHiLo("abort", hv, lv);
    endtask

    task automatic ovfTest(input aluOpE op, input logic [31:0] a, input logic [31:0] b);
        idExeT t;
        logic  ovf;
        t = mkInstr(op, a, b);
        t.ovfTrap = (op == ADD) || (op == SUB);
        ovf = ovfModel(op, a, b);
        issue(t, NoFwd, NoFwd, NoFwd);
        checkVal({op.name(), " excOverflow/gprWr"}, {30'b0, ovf, !ovf},
                 {30'b0, exeOut.excOverflow, exeOut.regsWr.gprWr});
        checkVal({op.name(), " result"}, aluModel(op, a, b), exeOut.result);
    endtask

    initial begin
        void'($urandom(89));
        errCount = 0;
        checkCount = 0;
        pcNext = 32'h0040_0000;
        rstN = 1'b0;
        idIn = '0;
        exeWr = 1'b0;
        exeFlush = 1'b0;
        memFwd = '0;
        mem2Fwd = '0;
        wbFwd = '0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(negedge clk);
        checkVal("reset outputs", 32'd0,
                 {26'b0, branchFlush, mulDivStall, exeOut.excOverflow, exeOut.regsWr});
        readHiLo("reset", 32'd0, 32'd0);
        foreach (AluOps[i]) begin
            for (int r = 0; r < NumAlu; r++) begin
                aluTest(AluOps[i], (AluOps[i] inside {SLL, SRL, SRA}) && r[0],
                        (AluOps[i] == LUI) || (!(AluOps[i] inside {SLL, SRL, SRA}) && r[1]));
            end
        end
        repeat (NumFwd) fwdTest();
        branchTest(BEQ, 32'h1234, 32'h1234, 1'b1);
        branchTest(BEQ, 32'h1234, 32'h1235, 1'b0);
        branchTest(BNE, 32'h55, 32'h55, 1'b0);
        branchTest(BNE, 32'h55, 32'hAA, 1'b1);
        branchTest(BLEZ, 32'd0, 32'd0, 1'b1);
        branchTest(BLEZ, 32'hFFFF_FFF0, 32'd0, 1'b0);
        branchTest(BLEZ, 32'd9, 32'd0, 1'b1);
        branchTest(BGTZ, 32'd9, 32'd0, 1'b1);
        branchTest(BGTZ, 32'd0, 32'd0, 1'b0);
        branchTest(BGTZ, 32'h8000_0000, 32'd0, 1'b1);
        branchTest(J, 32'd0, 32'd0, 1'b0);
        branchTest(JAL, 32'd0, 32'd0, 1'b0);
        branchTest(JR, 32'h0040_1230, 32'd0, 1'b1);
        for (int r = 0; r < NumMd; r++) begin
            mdTest(MULT, $urandom(), $urandom());
            mdTest(MULTU, $urandom(), $urandom());
            mdTest(DIV, $urandom(), $urandom() >> (r * 5));
            mdTest(DIVU, $urandom(), $urandom() >> (r * 5));
        end
        mdTest(DIV, $urandom(), 32'd0);
        mdTest(DIVU, $urandom(), 32'd0);
        moveHiLo($urandom(), $urandom());
        flushHoldTest();
        ovfTest(ADD, 32'h7FFF_FFFF, 32'd1);
        ovfTest(ADDU, 32'h7FFF_FFFF, 32'd1);
        ovfTest(ADD, 32'h8000_0000, 32'h8000_0000);
        ovfTest(SUB, 32'h8000_0000, 32'd1);
        ovfTest(SUBU, 32'h8000_0000, 32'd1);
        ovfTest(ADD, 32'd5, 32'd7);
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TestCycles * ClkPeriod);
        $display("watchdog expired, run did not finish within %0d cycles", TestCycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: sim.f
hw/exePkg.sv
hw/exeStageReg.sv
hw/operandForward.sv
hw/aluCore.sv
hw/mulDivHiLo.sv
hw/exeCtrl.sv
hw/exeTop.sv
dv/exeTb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - hw/exePkg.sv
  - hw/exeStageReg.sv
  - hw/operandForward.sv
  - hw/aluCore.sv
  - hw/mulDivHiLo.sv
  - hw/exeCtrl.sv
  - hw/exeTop.sv
  - target: simulation
    files:
      - dv/exeTb.sv
